// File: cache_pkg.sv
// widths, types and encodings shared by the two-way data cache
// imported by the way interface and every RTL module
`default_nettype none

package cache_pkg;

    localparam int INDEX_W_DEFAULT = 8;     // 256 sets
    localparam int OFFSET_W        = 4;     // byte offset inside a block
    localparam int WORDS_PER_BLOCK = 4;     // banks per way

    // tag keeps whatever the index and offset leave of a 32-bit address
    function automatic int tag_width(input int index_w);
        return 32 - index_w - OFFSET_W;
    endfunction

    localparam int TAG_W_DEFAULT = tag_width(INDEX_W_DEFAULT);

    typedef logic [31:0]                   word_t;
    typedef logic [3:0]                    strb_t;   // one bit per byte lane
    typedef logic [TAG_W_DEFAULT-1:0]      tag_t;
    typedef logic [1:0]                    bank_t;   // word select, offset[3:2]
    typedef logic [WORDS_PER_BLOCK*32-1:0] block_t;  // bank 0 in the low word

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITEHIT,
        S_MISS,
        S_WRITEBACK,   // dirty victim goes out first
        S_REPLACE,     // block read request
        S_REFILL       // beats coming back
    } state_e;

endpackage

`default_nettype wire

// File: way_if.sv
// link between the cache controller and one cache way
// controller drives reads, writes and the compare tag, the way returns held read data
`default_nettype none

interface way_if import cache_pkg::*; #(
    parameter int INDEX_W = INDEX_W_DEFAULT
) ();

    // controller to way
    logic                        rd_en;       // starts a synchronous read
    logic [INDEX_W-1:0]          rd_index;
    logic [INDEX_W-1:0]          wr_index;
    logic                        tag_we;      // writes cmp_tag and sets valid
    strb_t [WORDS_PER_BLOCK-1:0] bank_we;     // byte enables per bank
    word_t                       wr_word;
    logic                        set_dirty;
    logic                        clear_dirty;
    tag_t                        cmp_tag;

    // way to controller, held until the next rd_en
    logic                        hit;
    logic                        valid;
    logic                        dirty;
    tag_t                        tag;
    block_t                      block;

    modport controller (
        output rd_en, rd_index, wr_index, tag_we, bank_we, wr_word,
        output set_dirty, clear_dirty, cmp_tag,
        input  hit, valid, dirty, tag, block
    );

    modport way (
        input  rd_en, rd_index, wr_index, tag_we, bank_we, wr_word,
        input  set_dirty, clear_dirty, cmp_tag,
        output hit, valid, dirty, tag, block
    );

endinterface

`default_nettype wire

// File: cache_way.sv
// one way of the cache: tag, valid, dirty and four data banks
// reads are synchronous and held, hit compares the held tag
`default_nettype none

module cache_way import cache_pkg::*; #(
    parameter int INDEX_W = INDEX_W_DEFAULT
) (
    input  logic  clk,
    input  logic  reset,
    way_if.way    way
);

    localparam int SETS = 2 ** INDEX_W;

    tag_t            tag_mem  [SETS];
    word_t           data_mem [WORDS_PER_BLOCK][SETS];
    logic [SETS-1:0] valid_bits;
    logic [SETS-1:0] dirty_bits;

    // read side, held between reads
    logic            valid_q;
    logic            dirty_q;
    tag_t            tag_q;
    block_t          block_q;

    // valid and dirty flags per set
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_q    <= 1'b0;
            dirty_q    <= 1'b0;
        end else begin
            if (way.tag_we)
                valid_bits[way.wr_index] <= 1'b1;   // line now owned

            if (way.set_dirty)
                dirty_bits[way.wr_index] <= 1'b1;
            else if (way.clear_dirty)
                dirty_bits[way.wr_index] <= 1'b0;

            if (way.rd_en) begin
                valid_q <= valid_bits[way.rd_index];
                dirty_q <= dirty_bits[way.rd_index];
            end
        end
    end

    // tag array
    always_ff @(posedge clk) begin
        if (way.tag_we)
            tag_mem[way.wr_index] <= way.cmp_tag;
        if (way.rd_en)
            tag_q <= tag_mem[way.rd_index];
    end

    // data banks with byte lanes
    always_ff @(posedge clk) begin
        for (int b = 0; b < WORDS_PER_BLOCK; b++) begin
            for (int k = 0; k < 4; k++) begin
                if (way.bank_we[b][k])
                    data_mem[b][way.wr_index][8*k +: 8] <= way.wr_word[8*k +: 8];
            end
        end

        if (way.rd_en) begin
            for (int b = 0; b < WORDS_PER_BLOCK; b++)
                block_q[32*b +: 32] <= data_mem[b][way.rd_index];
        end
    end

    // compare against the buffered request tag
    assign way.hit   = valid_q && (tag_q == way.cmp_tag);
    assign way.valid = valid_q;
    assign way.dirty = dirty_q;
    assign way.tag   = tag_q;
    assign way.block = block_q;

endmodule

`default_nettype wire

// File: cache_ctrl.sv
// cache controller: FSM, request buffer, LRU and refill sequencing
// drives both ways through way_if and the memory bus as block reads and writes
`default_nettype none

module cache_ctrl import cache_pkg::*; #(
    parameter int INDEX_W = INDEX_W_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,

    way_if.controller           w0,
    way_if.controller           w1,

    // cpu side
    input  logic                valid,
    input  op_e                 op,
    input  logic [INDEX_W-1:0]  index,
    input  tag_t                tag,
    input  logic [OFFSET_W-1:0] offset,
    input  strb_t               wstrb,
    input  word_t               wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output word_t               rdata,

    // memory read side
    output logic                rd_req,
    output logic [31:0]         rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  word_t               ret_data,

    // memory write side
    output logic                wr_req,
    output logic [31:0]         wr_addr,
    output block_t              wr_data,
    input  logic                wr_rdy
);

    localparam int TAG_W = tag_width(INDEX_W);

    state_e state_q;
    state_e state_d;

    // request buffer
    op_e                req_op;
    logic [INDEX_W-1:0] req_index;
    tag_t               req_tag;
    bank_t              req_bank;
    strb_t              req_wstrb;
    word_t              req_wdata;

    logic [2**INDEX_W-1:0] lru_q;    // set bit means way1 is the LRU way
    logic                  hit_way_q;
    logic                  victim_q;
    bank_t                 beat_q;   // refill beat counter

    logic  cache_hit;
    logic  victim_pick;
    logic  victim_dirty;
    logic  req_beat;                 // returned beat is the requested word
    word_t hit_word;
    word_t refill_word;
    word_t way_wdata;
    tag_t  victim_tag;
    strb_t [WORDS_PER_BLOCK-1:0] bank_we0;
    strb_t [WORDS_PER_BLOCK-1:0] bank_we1;

    assign cache_hit   = w0.hit || w1.hit;
    // invalid way first, then LRU
    assign victim_pick = !w0.valid ? 1'b0 : (!w1.valid ? 1'b1 : lru_q[req_index]);
    assign victim_dirty = victim_q ? (w1.valid && w1.dirty) : (w0.valid && w0.dirty);
    assign req_beat    = (state_q == S_REFILL) && ret_valid && (beat_q == req_bank);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (valid)
                    state_d = S_LOOKUP;
            end
            S_LOOKUP: begin
                if (!cache_hit)
                    state_d = S_MISS;
                else if (req_op == OP_WRITE)
                    state_d = S_WRITEHIT;
                else
                    state_d = S_IDLE;
            end
            S_WRITEHIT:  state_d = S_IDLE;
            S_MISS:      state_d = victim_dirty ? S_WRITEBACK : S_REPLACE;
            S_WRITEBACK: begin
                if (wr_rdy)
                    state_d = S_REPLACE;
            end
            S_REPLACE: begin
                if (rd_rdy)
                    state_d = S_REFILL;
            end
            S_REFILL: begin
                if (ret_valid && ret_last)
                    state_d = S_IDLE;
            end
            default:     state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= S_IDLE;
            lru_q     <= '0;
            hit_way_q <= 1'b0;
            victim_q  <= 1'b0;
            beat_q    <= '0;
        end else begin
            state_q <= state_d;

            if (state_q == S_LOOKUP) begin
                hit_way_q <= w1.hit;            // used by S_WRITEHIT
                victim_q  <= victim_pick;       // held through the whole miss
                if (cache_hit)
                    lru_q[req_index] <= w0.hit; // the other way becomes LRU
            end

            if (state_q == S_REPLACE)
                beat_q <= '0;
            else if ((state_q == S_REFILL) && ret_valid)
                beat_q <= beat_q + 2'd1;        // gaps in ret_valid stall it

            if ((state_q == S_REFILL) && ret_valid && ret_last)
                lru_q[req_index] <= ~victim_q;  // refilled line is MRU
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_op    <= op;
            req_index <= index;
            req_tag   <= tag;
            req_bank  <= offset[OFFSET_W-1 -: 2];
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    // store bytes merged into the requested beat on a write miss
    always_comb begin
        refill_word = ret_data;
        if ((req_op == OP_WRITE) && (beat_q == req_bank)) begin
            for (int k = 0; k < 4; k++) begin
                if (req_wstrb[k])
                    refill_word[8*k +: 8] = req_wdata[8*k +: 8];
            end
        end
    end

    always_comb begin
        bank_we0 = '0;
        bank_we1 = '0;
        if (state_q == S_WRITEHIT) begin
            if (hit_way_q)
                bank_we1[req_bank] = req_wstrb;
            else
                bank_we0[req_bank] = req_wstrb;
        end else if ((state_q == S_REFILL) && ret_valid) begin
            if (victim_q)
                bank_we1[beat_q] = '1;          // whole word per beat
            else
                bank_we0[beat_q] = '1;
        end
    end

    assign way_wdata = (state_q == S_WRITEHIT) ? req_wdata : refill_word;

    assign w0.rd_en       = addr_ok;
    assign w0.rd_index    = index;
    assign w0.wr_index    = req_index;
    assign w0.tag_we      = req_beat && !victim_q;
    assign w0.bank_we     = bank_we0;
    assign w0.wr_word     = way_wdata;
    assign w0.set_dirty   = ((state_q == S_WRITEHIT) && !hit_way_q) ||
                            (req_beat && !victim_q && (req_op == OP_WRITE));
    assign w0.clear_dirty = req_beat && !victim_q && (req_op == OP_READ);
    assign w0.cmp_tag     = req_tag;

    assign w1.rd_en       = addr_ok;
    assign w1.rd_index    = index;
    assign w1.wr_index    = req_index;
    assign w1.tag_we      = req_beat && victim_q;
    assign w1.bank_we     = bank_we1;
    assign w1.wr_word     = way_wdata;
    assign w1.set_dirty   = ((state_q == S_WRITEHIT) && hit_way_q) ||
                            (req_beat && victim_q && (req_op == OP_WRITE));
    assign w1.clear_dirty = req_beat && victim_q && (req_op == OP_READ);
    assign w1.cmp_tag     = req_tag;

    // cpu side
    assign addr_ok  = (state_q == S_IDLE) && valid;
    assign data_ok  = ((state_q == S_LOOKUP) && cache_hit && (req_op == OP_READ)) ||
                      (state_q == S_WRITEHIT) || req_beat;
    assign hit_word = w1.hit ? w1.block[32*req_bank +: 32] : w0.block[32*req_bank +: 32];
    assign rdata    = (state_q == S_REFILL) ? ret_data : hit_word;

    // bus side, victim tag and block stay held from the lookup read
    assign victim_tag = victim_q ? w1.tag : w0.tag;
    assign rd_req  = (state_q == S_REPLACE);
    assign rd_addr = {req_tag[TAG_W-1:0], req_index, {OFFSET_W{1'b0}}};
    assign wr_req  = (state_q == S_WRITEBACK);
    assign wr_addr = {victim_tag[TAG_W-1:0], req_index, {OFFSET_W{1'b0}}};
    assign wr_data = victim_q ? w1.block : w0.block;

endmodule

`default_nettype wire

// File: cache_top.sv
// two-way write-back data cache with a CPU request port and a block memory bus
// the two ways sit side by side under one controller
`default_nettype none

module cache_top import cache_pkg::*; #(
    parameter int INDEX_W = INDEX_W_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,

    // cpu side
    input  logic                valid,
    input  op_e                 op,
    input  logic [INDEX_W-1:0]  index,
    input  tag_t                tag,
    input  logic [OFFSET_W-1:0] offset,
    input  strb_t               wstrb,
    input  word_t               wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output word_t               rdata,

    // memory read side
    output logic                rd_req,
    output logic [31:0]         rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  word_t               ret_data,

    // memory write side
    output logic                wr_req,
    output logic [31:0]         wr_addr,
    output block_t              wr_data,
    input  logic                wr_rdy
);

    way_if #(.INDEX_W(INDEX_W)) if_w0 ();
    way_if #(.INDEX_W(INDEX_W)) if_w1 ();

    cache_way #(.INDEX_W(INDEX_W)) way0 (
        .clk   (clk),
        .reset (reset),
        .way   (if_w0.way)
    );

    cache_way #(.INDEX_W(INDEX_W)) way1 (
        .clk   (clk),
        .reset (reset),
        .way   (if_w1.way)
    );

    cache_ctrl #(.INDEX_W(INDEX_W)) ctrl0 (
        .clk       (clk),
        .reset     (reset),
        .w0        (if_w0.controller),
        .w1        (if_w1.controller),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
// memory on the cache bus side for the testbench
// answers block reads in four beats, takes block writes, ready and beat gaps follow random bits
`default_nettype none

module tb_mem_model import cache_pkg::*; #(
    parameter word_t FILL_KEY = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [2:0]  rand_bits,   // [0] rd_rdy, [1] wr_rdy, [2] ret_valid
    input  logic        rd_req,
    input  logic [31:0] rd_addr,
    output logic        rd_rdy,
    output logic        ret_valid,
    output logic        ret_last,
    output word_t       ret_data,
    input  logic        wr_req,
    input  logic [31:0] wr_addr,
    input  block_t      wr_data,
    output logic        wr_rdy
);
    timeunit 1ns;
    timeprecision 100ps;

    word_t       store [logic [29:0]];  // words written back so far
    logic        busy;
    logic [1:0]  beat;
    logic [27:0] base;                  // block address of the open read
    logic        rd_wait;
    logic        wr_wait;

    // untouched words follow the fill pattern
    function automatic word_t mem_word(input logic [29:0] waddr);
        if (store.exists(waddr))
            return store[waddr];
        return {2'b00, waddr} ^ FILL_KEY;
    endfunction

    initial begin
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        busy      = 1'b0;
        beat      = 2'd0;
        base      = '0;
        rd_wait   = 1'b0;
        wr_wait   = 1'b0;
        forever begin
            @(posedge clk);
            if (reset) begin
                busy    = 1'b0;
                beat    = 2'd0;
                rd_wait = 1'b0;
                wr_wait = 1'b0;
            end else begin
                if (busy && ret_valid) begin
                    busy = (beat != 2'd3);  // beat 3 closes the read
                    beat = beat + 2'd1;
                end else if (rd_req && rd_rdy) begin
                    busy = 1'b1;
                    beat = 2'd0;
                    base = rd_addr[31:4];
                end
                if (wr_req && wr_rdy) begin
                    for (int i = 0; i < 4; i++)
                        store[{wr_addr[31:4], 2'(i)}] = wr_data[32*i +: 32];
                end
                // every request waits at least one cycle
                rd_wait = rd_req && !rd_rdy;
                wr_wait = wr_req && !wr_rdy;
            end
            #1;
            rd_rdy    = rd_wait && rand_bits[0];
            wr_rdy    = wr_wait && rand_bits[1];
            ret_valid = busy && rand_bits[2];
            ret_last  = (beat == 2'd3);
            ret_data  = mem_word({base, beat});
        end
    end

endmodule

`default_nettype wire

// File: cache_tb.sv
// testbench for the two-way data cache with concurrent assertions as the checks
// a shadow memory gives the expected words and the memory model stalls the bus at random
`default_nettype none

module cache_tb import cache_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam word_t FILL_KEY = 32'h5a3c_96e1;
    localparam int    ACCESSES = 14;
    localparam int    LIMIT    = 200 * ACCESSES;

    logic        clk = 1'b0;
    logic        reset;
    logic        valid;
    op_e         op;
    logic [7:0]  index;
    tag_t        tag;
    logic [3:0]  offset;
    strb_t       wstrb;
    word_t       wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    logic [31:0] wr_addr;
    block_t      wr_data;
    logic        wr_rdy;

    // expectations of the open access
    op_e         cur_op       = OP_READ;
    logic        expect_hit   = 1'b0;
    word_t       exp_word     = '0;
    logic [31:0] exp_rd_addr  = '0;
    logic [31:0] victim_addr  = '0;
    block_t      victim_block = '0;
    word_t       shadow [logic [29:0]];
    logic [31:0] lfsr         = 32'hdc14_eeed;
    int          errors       = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycles       = 0;
    int          wb_count     = 0;

    cache_top dut0 (.*);

    tb_mem_model #(.FILL_KEY(FILL_KEY)) mem0 (
        .clk       (clk),
        .reset     (reset),
        .rand_bits (lfsr[2:0]),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t shadow_word(input logic [29:0] waddr);
        if (shadow.exists(waddr))
            return shadow[waddr];
        return {2'b00, waddr} ^ FILL_KEY;
    endfunction

    function automatic block_t shadow_block(input logic [31:0] addr);
        block_t b;
        for (int i = 0; i < 4; i++)
            b[32*i +: 32] = shadow_word({addr[31:4], 2'(i)});
        return b;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t d, input strb_t s);
        word_t w;
        w = old;
        for (int k = 0; k < 4; k++) begin
            if (s[k])
                w[8*k +: 8] = d[8*k +: 8];
        end
        return w;
    endfunction

    always @(posedge clk)
        lfsr <= lfsr_step(lfsr_step(lfsr_step(lfsr)));  // one step per bit taken

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (wr_req && wr_rdy)
            wb_count <= wb_count + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, an access never completed", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    check_reset: assert property (@(posedge clk)
        reset |=> !addr_ok && !data_ok && !rd_req && !wr_req)
        else begin
            $display("ERROR %0t addr_ok/data_ok/rd_req/wr_req got %b%b%b%b expected 0000",
                     $time, $sampled(addr_ok), $sampled(data_ok), $sampled(rd_req),
                     $sampled(wr_req));
            errors++;
        end

    check_rdata: assert property (@(posedge clk) disable iff (reset)
        data_ok && cur_op == OP_READ |-> rdata == exp_word)
        else begin
            $display("ERROR %0t rdata got %h expected %h", $time, $sampled(rdata), exp_word);
            errors++;
        end

    check_rd_addr: assert property (@(posedge clk) disable iff (reset)
        rd_req |-> rd_addr == exp_rd_addr)
        else begin
            $display("ERROR %0t rd_addr got %h expected %h", $time, $sampled(rd_addr),
                     exp_rd_addr);
            errors++;
        end

    check_read_hit: assert property (@(posedge clk) disable iff (reset)
        data_ok && expect_hit && cur_op == OP_READ |-> $past(addr_ok))
        else begin
            $display("%0t read hit did not answer one cycle after addr_ok", $time);
            errors++;
        end

    check_write_hit: assert property (@(posedge clk) disable iff (reset)
        data_ok && expect_hit && cur_op == OP_WRITE |-> $past(addr_ok, 2) && !$past(addr_ok))
        else begin
            $display("%0t write hit did not answer two cycles after addr_ok", $time);
            errors++;
        end

    check_no_bus: assert property (@(posedge clk) disable iff (reset)
        expect_hit |-> !rd_req && !wr_req)
        else begin
            $display("%0t bus request during an access that should hit", $time);
            errors++;
        end

    check_wr_addr: assert property (@(posedge clk) disable iff (reset)
        wr_req |-> wr_addr == victim_addr)
        else begin
            $display("ERROR %0t wr_addr got %h expected %h", $time, $sampled(wr_addr),
                     victim_addr);
            errors++;
        end

    check_wr_data: assert property (@(posedge clk) disable iff (reset)
        wr_req |-> wr_data == victim_block)
        else begin
            $display("ERROR %0t wr_data got %h expected %h", $time, $sampled(wr_data),
                     victim_block);
            errors++;
        end

    check_rd_hold: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            $display("%0t rd_req dropped or rd_addr moved while waiting on rd_rdy", $time);
            errors++;
        end

    check_wr_hold: assert property (@(posedge clk) disable iff (reset)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else begin
            $display("%0t wr_req dropped or its address or data moved while waiting", $time);
            errors++;
        end

    // one CPU access that returns after data_ok
    task automatic access(input op_e o, input logic [31:0] a, input strb_t s,
                          input word_t d, input logic hit);
        @(posedge clk);
        #1;
        cur_op      = o;
        expect_hit  = hit;
        exp_rd_addr = {a[31:4], 4'h0};
        if (o == OP_WRITE)
            shadow[a[31:2]] = merge_bytes(shadow_word(a[31:2]), d, s);
        exp_word = shadow_word(a[31:2]);
        valid    = 1'b1;
        op       = o;
        tag      = a[31:12];
        index    = a[11:4];
        offset   = a[3:0];
        wstrb    = s;
        wdata    = d;
        @(negedge clk);
        while (!addr_ok)
            @(negedge clk);
        @(posedge clk);
        #1;
        valid = 1'b0;
        @(negedge clk);
        while (!data_ok)
            @(negedge clk);
    endtask

    // lets the last assertions of the test fire first
    task automatic finish_test(input string name, input int start, input logic ok);
        @(posedge clk);
        #2;
        if (ok && errors == start) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed", name);
        end
    endtask

    initial begin
        int   start;
        int   wb_before;
        logic ok;
        reset  = 1'b1;
        valid  = 1'b0;
        op     = OP_READ;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        finish_test("reset state", 0, 1'b1);

        start = errors;
        access(OP_READ, 32'h0001_2018, 4'h0, 32'h0, 1'b0);
        finish_test("read miss and refill", start, 1'b1);

        start = errors;
        access(OP_READ, 32'h0001_2018, 4'h0, 32'h0, 1'b1);
        finish_test("read hit", start, 1'b1);

        start = errors;
        access(OP_WRITE, 32'h0001_2014, 4'b0110, 32'h1234_5678, 1'b1);
        access(OP_READ, 32'h0001_2014, 4'h0, 32'h0, 1'b1);
        finish_test("partial write hit", start, 1'b1);

        start = errors;
        access(OP_WRITE, 32'h0003_4028, 4'b1001, 32'hdead_beef, 1'b0);
        access(OP_READ, 32'h0003_4028, 4'h0, 32'h0, 1'b1);
        finish_test("write miss merge", start, 1'b1);

        // set 5 gets A written and B touched, then C evicts A
        start       = errors;
        ok          = 1'b1;
        victim_addr = 32'h0010_0050;
        access(OP_WRITE, 32'h0010_0054, 4'hf, 32'hcafe_f00d, 1'b0);
        access(OP_READ, 32'h0020_0050, 4'h0, 32'h0, 1'b0);
        access(OP_READ, 32'h0020_0054, 4'h0, 32'h0, 1'b1);
        victim_block = shadow_block(victim_addr);
        wb_before    = wb_count;
        access(OP_READ, 32'h0030_0058, 4'h0, 32'h0, 1'b0);
        access(OP_READ, 32'h0020_0050, 4'h0, 32'h0, 1'b1);
        assert (wb_count == wb_before + 1)
        else begin
            $display("dirty victim was not written back exactly once");
            ok = 1'b0;
        end
        finish_test("dirty eviction and LRU", start, ok);

        start       = errors;
        ok          = 1'b1;
        victim_addr = 32'h0040_0090;
        access(OP_WRITE, 32'h0040_0094, 4'hf, 32'h0bad_c0de, 1'b0);
        access(OP_WRITE, 32'h0050_0098, 4'b0011, 32'h7766_5544, 1'b0);
        victim_block = shadow_block(victim_addr);
        wb_before    = wb_count;
        access(OP_READ, 32'h0060_009c, 4'h0, 32'h0, 1'b0);
        assert (wb_count == wb_before + 1)
        else begin
            $display("older dirty line was not written back exactly once");
            ok = 1'b0;
        end
        finish_test("bus back-pressure", start, ok);

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
cache_pkg.sv
way_if.sv
cache_way.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module cache_tb -f src.f -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
